/* run.sh */
#!/usr/bin/env bash
# build and run the USB line buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module usbBufTb -f vlog.f -o usbBufSim
./obj_dir/usbBufSim | tee sim.log
if grep -q "Done: errors found" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

/* source/usbBitTimer.sv */
// bit period strobe generator, realigned to mid-bit on received line transitions
`timescale 1ns/1ns
`default_nettype none

module usbBitTimer #(
	parameter int BitDivide = 4
) (
	input wire clock,
	input wire reset,
	input wire resync,
	output logic bitStrobe
);

	localparam int CountBits = $clog2(BitDivide);
	localparam logic [CountBits-1:0] FullLoad = CountBits'(BitDivide - 1);
	// resync lands two clocks after the edge, so half a period minus one
	localparam logic [CountBits-1:0] HalfLoad = CountBits'(BitDivide / 2 - 1);

	logic [CountBits-1:0] count;

	// no strobe on the resync cycle, the line has only just changed
	assign bitStrobe = (count == '0) && !resync;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count <= FullLoad;
		end
		else if (resync)
		begin
			count <= HalfLoad;
		end
		else if (count == '0)
		begin
			count <= FullLoad;
		end
		else
		begin
			count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/usbBufMmioCtrl.sv */
// MMIO bus controller with address decode, buffer arbitration and packet pointer registers
`timescale 1ns/1ns
`default_nettype none

module usbBufMmioCtrl #(
	parameter int BufAddrBits = 8
) (
	input wire clock,
	input wire reset,
	input wire usbBufPkg::mmioReq_s mmioReq,
	output wire usbBufPkg::mmioResp_s mmioResp,
	input wire usbBufPkg::rxStatus_s rxStatus,
	input wire txBusy,
	input wire txAdvance,
	input wire usbBufPkg::bufWord_s rxRdData,
	input wire usbBufPkg::bufWord_s txRdData,
	output logic [BufAddrBits-1:0] rxRdAddr,
	output logic [BufAddrBits-1:0] rxWrAddr,
	output logic [BufAddrBits-1:0] txRdAddr,
	output logic [BufAddrBits-1:0] txWrAddr,
	output usbBufPkg::bufWord_s rxWrData,
	output usbBufPkg::bufWord_s txWrData,
	output logic rxWrEn,
	output logic txWrEn,
	output logic txPending,
	output usbBufPkg::symbol_t txSymbol
);

	// top bit of the word index inside a pointer
	localparam int WordTop = BufAddrBits + 1;

	usbBufPkg::mmioReq_s reqReg;
	usbBufPkg::mmioResp_s respReg;
	usbBufPkg::mmioWord_u reqWord;
	usbBufPkg::mmioWord_u rdWord;
	usbBufPkg::bufWord_s busSymbols;
	usbBufPkg::bufWord_s selWord;
	usbBufPkg::bufWord_s mergedWord;
	usbBufPkg::symbol_t rmwSymbol;

	logic [usbBufPkg::PtrBits-1:0] rxStart;
	logic [usbBufPkg::PtrBits-1:0] rxEnd;
	logic [usbBufPkg::PtrBits-1:0] txStart;
	logic [usbBufPkg::PtrBits-1:0] txEnd;
	logic [BufAddrBits-1:0] busWord;
	logic [7:0] regOffset;

	logic isRead;
	logic isWrite;
	logic sizeOk;
	logic lowPage;
	logic bufSel;
	logic ctlSel;
	logic reqActive;
	logic txSide;
	logic bufBusy;
	logic bufIssue;
	logic bufIssued;
	logic done;
	logic rmwPending;

	assign mmioResp = respReg;

	// request decode
	always_comb
	begin
		reqWord = reqReg.data;
		isRead = reqReg.opm[4:3] == 2'b01;
		isWrite = reqReg.opm[4:3] == 2'b10;
		sizeOk = reqReg.opm[2:0] == 3'b011;
		lowPage = reqReg.addr[31:16] == 16'h0000;
		bufSel = lowPage && (reqReg.addr[15:12] == usbBufPkg::BufWindow[15:12]);
		ctlSel = lowPage && (reqReg.addr[15:8] == usbBufPkg::CtlWindow[15:8]);
		reqActive = (isRead || isWrite) && (bufSel || ctlSel);
		txSide = reqReg.addr[11];
		busWord = reqReg.addr[BufAddrBits+2:3];
		regOffset = reqReg.addr[7:0];
		// receiver writes and both packet directions lock the buffers
		bufBusy = rxStatus.busy || rxStatus.valid || rmwPending || txBusy;
		bufIssue = reqActive && bufSel && !done && !bufIssued && !bufBusy;
	end

	// read data and write symbols in both word forms
	always_comb
	begin
		selWord = txSide ? txRdData : rxRdData;
		rdWord = '0;
		for (int i = 0; i < 4; i++)
		begin
			busSymbols.sym[i] = reqWord.bufLanes.lane[i].sym;
		end
		if (ctlSel)
		begin
			if (sizeOk && regOffset == usbBufPkg::RegRxPtr)
			begin
				rdWord.ptrPair.startPtr = rxStart;
				rdWord.ptrPair.endPtr = rxEnd;
			end
			else if (sizeOk && regOffset == usbBufPkg::RegTxPtr)
			begin
				rdWord.ptrPair.startPtr = txStart;
				rdWord.ptrPair.endPtr = txEnd;
			end
			else if (sizeOk && regOffset == usbBufPkg::RegStatus)
			begin
				rdWord = {62'b0, txBusy, rxStatus.busy};
			end
		end
		else
		begin
			for (int i = 0; i < 4; i++)
			begin
				rdWord.bufLanes.lane[i].sym = selWord.sym[i];
			end
		end
	end

	// buffer ports; read ports follow the pointers unless the bus takes them
	always_comb
	begin
		mergedWord = rxRdData;
		mergedWord.sym[rxEnd[1:0]] = rmwSymbol;
		rxRdAddr = (bufIssue && !txSide) ? busWord : rxEnd[WordTop:2];
		txRdAddr = (bufIssue && txSide) ? busWord : txStart[WordTop:2];
		rxWrEn = rmwPending || (bufIssue && isWrite && !txSide);
		rxWrAddr = rmwPending ? rxEnd[WordTop:2] : busWord;
		rxWrData = rmwPending ? mergedWord : busSymbols;
		txWrEn = bufIssue && isWrite && txSide;
		txWrAddr = busWord;
		txWrData = busSymbols;
		txPending = txStart != txEnd;
		txSymbol = txRdData.sym[txStart[1:0]];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqReg.opm <= '0;
		end
		else
		begin
			reqReg.opm <= mmioReq.opm;
		end
		reqReg.addr <= mmioReq.addr;
		reqReg.data <= mmioReq.data;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rxStart <= '0;
			rxEnd <= '0;
			txStart <= '0;
			txEnd <= '0;
			respReg.ok <= usbBufPkg::MmioReady;
			done <= 1'b0;
			bufIssued <= 1'b0;
			rmwPending <= 1'b0;
		end
		else
		begin
			// merge happens the cycle after the request, once the word is read
			rmwPending <= rxStatus.valid;
			if (rxStatus.valid)
			begin
				rmwSymbol <= rxStatus.symbol;
			end
			if (rmwPending)
			begin
				rxEnd <= rxEnd + 1'b1;
			end
			if (txAdvance)
			begin
				txStart <= txStart + 1'b1;
			end

			if (!reqActive)
			begin
				done <= 1'b0;
				bufIssued <= 1'b0;
				respReg.ok <= usbBufPkg::MmioReady;
			end
			else if (done)
			begin
				respReg.ok <= usbBufPkg::MmioOk;
			end
			else if (ctlSel)
			begin
				respReg.ok <= usbBufPkg::MmioOk;
				respReg.data <= rdWord;
				done <= 1'b1;
				if (isWrite && sizeOk && regOffset == usbBufPkg::RegRxPtr)
				begin
					rxStart <= reqWord.ptrPair.startPtr;
					rxEnd <= reqWord.ptrPair.endPtr;
				end
				if (isWrite && sizeOk && regOffset == usbBufPkg::RegTxPtr)
				begin
					txStart <= reqWord.ptrPair.startPtr;
					txEnd <= reqWord.ptrPair.endPtr;
				end
			end
			else if (bufIssued)
			begin
				respReg.ok <= usbBufPkg::MmioOk;
				respReg.data <= rdWord;
				done <= 1'b1;
				bufIssued <= 1'b0;
			end
			else
			begin
				respReg.ok <= usbBufPkg::MmioHold;
				bufIssued <= bufIssue;
			end
		end
	end

endmodule

`default_nettype wire

/* source/usbBufPkg.sv */
// USB line buffer shared widths, bus encodings, address map and line states
`default_nettype none

package usbBufPkg;

	// pointer is word index plus symbol-in-word
	localparam int PtrBits = 10;
	localparam int SymBits = 9;

	// bit 8 marks end-of-packet, bits 7..0 carry a byte
	typedef logic [SymBits-1:0] symbol_t;

	localparam symbol_t EopSymbol = 9'h100;

	// symbol 0 in the low bits
	typedef struct packed {
		symbol_t [3:0] sym;
	} bufWord_s;

	typedef enum logic [1:0] {
		MmioReady = 2'b00,
		MmioOk = 2'b01,
		MmioHold = 2'b10
	} mmioOk_e;

	// opm bits 4..3 select read or write, bits 2..0 give the size
	typedef struct packed {
		logic [31:0] addr;
		logic [4:0] opm;
		logic [63:0] data;
	} mmioReq_s;

	typedef struct packed {
		logic [63:0] data;
		mmioOk_e ok;
	} mmioResp_s;

	typedef struct packed {
		logic [15-SymBits:0] pad;
		symbol_t sym;
	} busLane_s;

	typedef struct packed {
		busLane_s [3:0] lane;
	} bufLanes_s;

	typedef struct packed {
		logic [31-PtrBits:0] endPad;
		logic [PtrBits-1:0] endPtr;
		logic [31-PtrBits:0] startPad;
		logic [PtrBits-1:0] startPtr;
	} ptrPair_s;

	// buffer window sees symbol lanes, control page sees pointer pairs
	typedef union packed {
		bufLanes_s bufLanes;
		ptrPair_s ptrPair;
	} mmioWord_u;

	typedef struct packed {
		logic dp;
		logic dm;
	} usbLine_s;

	localparam usbLine_s LineJ = '{dp: 1'b1, dm: 1'b0};
	localparam usbLine_s LineK = '{dp: 1'b0, dm: 1'b1};
	localparam usbLine_s LineSe0 = '{dp: 1'b0, dm: 1'b0};

	localparam logic [15:0] BufWindow = 16'h8000;
	localparam logic [15:0] CtlWindow = 16'hE800;
	localparam logic [7:0] RegRxPtr = 8'h00;
	localparam logic [7:0] RegTxPtr = 8'h10;
	localparam logic [7:0] RegStatus = 8'h08;

	// receiver packet level plus one-cycle symbol write request
	typedef struct packed {
		logic busy;
		logic valid;
		symbol_t symbol;
	} rxStatus_s;

endpackage

`default_nettype wire

/* source/usbBufTop.sv */
// USB full-speed line buffer top level joining bus controller, bit timer, buffers and codecs
`timescale 1ns/1ns
`default_nettype none

module usbBufTop #(
	parameter int BitDivide = 4,
	parameter int BufAddrBits = 8
) (
	input wire clock,
	input wire reset,
	input wire usbBufPkg::mmioReq_s mmioReq,
	output wire usbBufPkg::mmioResp_s mmioResp,
	input wire usbBufPkg::usbLine_s lineIn,
	output wire usbBufPkg::usbLine_s lineOut,
	output wire lineOe
);

	wire bitStrobe;
	wire resync;
	wire txBusy;
	wire txAdvance;
	wire txPending;
	wire usbBufPkg::symbol_t txSymbol;
	wire usbBufPkg::rxStatus_s rxStatus;

	wire [BufAddrBits-1:0] rxRdAddr;
	wire [BufAddrBits-1:0] rxWrAddr;
	wire [BufAddrBits-1:0] txRdAddr;
	wire [BufAddrBits-1:0] txWrAddr;
	wire usbBufPkg::bufWord_s rxRdData;
	wire usbBufPkg::bufWord_s txRdData;
	wire usbBufPkg::bufWord_s rxWrData;
	wire usbBufPkg::bufWord_s txWrData;
	wire rxWrEn;
	wire txWrEn;

	usbBufMmioCtrl #(
		.BufAddrBits(BufAddrBits)
	) i_ctrl (
		.clock(clock),
		.reset(reset),
		.mmioReq(mmioReq),
		.mmioResp(mmioResp),
		.rxStatus(rxStatus),
		.txBusy(txBusy),
		.txAdvance(txAdvance),
		.rxRdData(rxRdData),
		.txRdData(txRdData),
		.rxRdAddr(rxRdAddr),
		.rxWrAddr(rxWrAddr),
		.txRdAddr(txRdAddr),
		.txWrAddr(txWrAddr),
		.rxWrData(rxWrData),
		.txWrData(txWrData),
		.rxWrEn(rxWrEn),
		.txWrEn(txWrEn),
		.txPending(txPending),
		.txSymbol(txSymbol)
	);

	usbBitTimer #(
		.BitDivide(BitDivide)
	) i_bitTimer (
		.clock(clock),
		.reset(reset),
		.resync(resync),
		.bitStrobe(bitStrobe)
	);

	usbPacketBuffer #(
		.BufAddrBits(BufAddrBits)
	) rxBuffer (
		.clock(clock),
		.rdAddr(rxRdAddr),
		.wrAddr(rxWrAddr),
		.wrData(rxWrData),
		.wrEn(rxWrEn),
		.rdData(rxRdData)
	);

	usbPacketBuffer #(
		.BufAddrBits(BufAddrBits)
	) txBuffer (
		.clock(clock),
		.rdAddr(txRdAddr),
		.wrAddr(txWrAddr),
		.wrData(txWrData),
		.wrEn(txWrEn),
		.rdData(txRdData)
	);

	usbRxDecoder i_rx (
		.clock(clock),
		.reset(reset),
		.lineIn(lineIn),
		.lineOe(lineOe),
		.bitStrobe(bitStrobe),
		.resync(resync),
		.rxStatus(rxStatus)
	);

	usbTxEncoder i_tx (
		.clock(clock),
		.reset(reset),
		.bitStrobe(bitStrobe),
		.txPending(txPending),
		.txSymbol(txSymbol),
		.txAdvance(txAdvance),
		.txBusy(txBusy),
		.lineOut(lineOut),
		.lineOe(lineOe)
	);

endmodule

`default_nettype wire

/* source/usbPacketBuffer.sv */
// packet symbol memory, four 9-bit symbols per word, one read and one write port
`timescale 1ns/1ns
`default_nettype none

module usbPacketBuffer #(
	parameter int BufAddrBits = 8
) (
	input wire clock,
	input wire [BufAddrBits-1:0] rdAddr,
	input wire [BufAddrBits-1:0] wrAddr,
	input wire usbBufPkg::bufWord_s wrData,
	input wire wrEn,
	output usbBufPkg::bufWord_s rdData
);

	localparam int Depth = 2 ** BufAddrBits;

	usbBufPkg::bufWord_s mem [0:Depth-1];

	always_ff @(posedge clock)
	begin
		if (wrEn)
		begin
			mem[wrAddr] <= wrData;
		end
	end

	// registered read, old data on a same-address write
	always_ff @(posedge clock)
	begin
		rdData <= mem[rdAddr];
	end

endmodule

`default_nettype wire

/* source/usbRxDecoder.sv */
// USB receiver with sync detect, NRZI decode, destuffing, byte assembly and EOP detect
`timescale 1ns/1ns
`default_nettype none

module usbRxDecoder (
	input wire clock,
	input wire reset,
	input wire usbBufPkg::usbLine_s lineIn,
	input wire lineOe,
	input wire bitStrobe,
	output logic resync,
	output usbBufPkg::rxStatus_s rxStatus
);

	usbBufPkg::usbLine_s lineMeta;
	usbBufPkg::usbLine_s lineSync;
	usbBufPkg::usbLine_s lineLast;
	usbBufPkg::usbLine_s prevLine;
	usbBufPkg::symbol_t wrSymbol;

	logic [7:0] bitShift;
	logic [7:0] shiftNext;
	logic [2:0] onesCount;
	logic [2:0] bitCount;
	logic inPacket;
	logic wrValid;
	logic lineBit;
	logic isData;

	// NRZI: no change is a one
	assign lineBit = lineSync == prevLine;
	assign shiftNext = {lineBit, bitShift[7:1]};
	assign isData = lineSync.dp != lineSync.dm;
	assign resync = !lineOe && (lineSync != lineLast);
	assign rxStatus = '{busy: inPacket, valid: wrValid, symbol: wrSymbol};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			lineMeta <= usbBufPkg::LineJ;
			lineSync <= usbBufPkg::LineJ;
			lineLast <= usbBufPkg::LineJ;
		end
		else
		begin
			lineMeta <= lineIn;
			lineSync <= lineMeta;
			lineLast <= lineSync;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			inPacket <= 1'b0;
			prevLine <= usbBufPkg::LineJ;
			bitShift <= 8'hFF;
			onesCount <= '0;
			bitCount <= '0;
			wrValid <= 1'b0;
		end
		else
		begin
			wrValid <= 1'b0;
			if (bitStrobe && !lineOe)
			begin
				if (!isData)
				begin
					// SE0 closes the packet
					if (inPacket)
					begin
						wrValid <= 1'b1;
						wrSymbol <= usbBufPkg::EopSymbol;
					end
					inPacket <= 1'b0;
					prevLine <= usbBufPkg::LineJ;
					bitShift <= 8'hFF;
				end
				else
				begin
					prevLine <= lineSync;
					if (!inPacket)
					begin
						bitShift <= shiftNext;
						// seven zeros then a one, KJKJKJKK on the line
						if (shiftNext == 8'h80)
						begin
							inPacket <= 1'b1;
							onesCount <= 3'd1;
							bitCount <= '0;
						end
					end
					else if (onesCount == 3'd6 && !lineBit)
					begin
						// stuffed zero
						onesCount <= '0;
					end
					else
					begin
						bitShift <= shiftNext;
						onesCount <= lineBit ? onesCount + 3'd1 : 3'd0;
						bitCount <= bitCount + 3'd1;
						if (bitCount == 3'd7)
						begin
							wrValid <= 1'b1;
							wrSymbol <= {1'b0, shiftNext};
						end
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/usbTxEncoder.sv */
// USB transmitter sequencing sync, NRZI data with bit stuffing, EOP and line drive
`timescale 1ns/1ns
`default_nettype none

module usbTxEncoder (
	input wire clock,
	input wire reset,
	input wire bitStrobe,
	input wire txPending,
	input wire usbBufPkg::symbol_t txSymbol,
	output logic txAdvance,
	output logic txBusy,
	output usbBufPkg::usbLine_s lineOut,
	output logic lineOe
);

	typedef enum logic [1:0] {
		TxIdle,
		TxSync,
		TxData,
		TxEop
	} txState_e;

	txState_e state;
	usbBufPkg::usbLine_s toggled;

	logic [7:0] shiftReg;
	logic [2:0] bitCount;
	logic [2:0] onesCount;
	logic [1:0] eopCount;
	logic stuffNow;
	logic dataBit;

	assign txBusy = state != TxIdle;
	assign stuffNow = onesCount == 3'd6;
	assign dataBit = shiftReg[0];
	assign toggled = (lineOut == usbBufPkg::LineJ) ? usbBufPkg::LineK : usbBufPkg::LineJ;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= TxIdle;
			lineOut <= usbBufPkg::LineJ;
			lineOe <= 1'b0;
			onesCount <= '0;
			bitCount <= '0;
			eopCount <= '0;
			txAdvance <= 1'b0;
		end
		else
		begin
			txAdvance <= 1'b0;
			if (bitStrobe)
			begin
				case (state)
					TxIdle:
					begin
						lineOut <= usbBufPkg::LineJ;
						lineOe <= 1'b0;
						if (txPending)
						begin
							// sync byte, sent LSB first
							state <= TxSync;
							shiftReg <= 8'h80;
							bitCount <= '0;
							onesCount <= '0;
						end
					end
					TxSync, TxData:
					begin
						lineOe <= 1'b1;
						if (stuffNow)
						begin
							// extra toggle, byte position held
							lineOut <= toggled;
							onesCount <= '0;
						end
						else
						begin
							lineOut <= dataBit ? lineOut : toggled;
							onesCount <= dataBit ? onesCount + 3'd1 : 3'd0;
							shiftReg <= shiftReg >> 1;
							bitCount <= bitCount + 3'd1;
							if (bitCount == 3'd7)
							begin
								eopCount <= '0;
								if (txPending && !txSymbol[8])
								begin
									shiftReg <= txSymbol[7:0];
									txAdvance <= 1'b1;
									state <= TxData;
								end
								else
								begin
									// marker symbol is consumed too
									txAdvance <= txPending;
									state <= TxEop;
								end
							end
						end
					end
					TxEop:
					begin
						if (eopCount == 2'd0 && stuffNow)
						begin
							lineOut <= toggled;
							onesCount <= '0;
						end
						else
						begin
							eopCount <= eopCount + 2'd1;
							case (eopCount)
								2'd0, 2'd1: lineOut <= usbBufPkg::LineSe0;
								2'd2: lineOut <= usbBufPkg::LineJ;
								default:
								begin
									lineOe <= 1'b0;
									state <= TxIdle;
								end
							endcase
						end
					end
					default:
					begin
						state <= TxIdle;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verification/usbBufTb.sv */
// testbench for the USB line buffer covering bus registers, buffer window, receive and transmit
`timescale 1ns/1ns
`default_nettype none

module usbBufTb;

	localparam int BitDivide = 4;
	localparam int NumRows = 3;
	localparam int BusTimeout = 200;
	localparam int StatusTimeout = 200;
	localparam int StartTimeout = 40;
	localparam int MaxSamples = 400;
	localparam logic [4:0] OpRead = 5'b01011;
	localparam logic [4:0] OpWrite = 5'b10011;
	localparam logic [4:0] OpIdle = 5'b00000;

	// one stimulus row, name is eight characters
	typedef struct packed {
		logic [63:0] name;
		logic [9:0] rxStart;
		logic [9:0] rxEnd;
		logic [9:0] txPtr;
		logic [7:0] count;
		logic [7:0] ffAt;
	} testRow_s;

	logic clock;
	logic reset;
	usbBufPkg::mmioReq_s mmioReq;
	usbBufPkg::mmioResp_s mmioResp;
	usbBufPkg::usbLine_s lineIn;
	usbBufPkg::usbLine_s lineOut;
	logic lineOe;

	testRow_s rows [0:NumRows-1];
	string testName;
	logic [31:0] lfsrState;
	logic [7:0] packet [$];
	logic [7:0] lineBytes [$];
	usbBufPkg::symbol_t symbols [$];
	usbBufPkg::usbLine_s samples [$];

	usbBufTop #(
		.BitDivide(BitDivide),
		.BufAddrBits(8)
	) i_dut (
		.clock(clock),
		.reset(reset),
		.mmioReq(mmioReq),
		.mmioResp(mmioResp),
		.lineIn(lineIn),
		.lineOut(lineOut),
		.lineOe(lineOe)
	);

	always #50 clock = ~clock;

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic logic [63:0] ptrWord(input logic [9:0] startPtr, input logic [9:0] endPtr);
		return {22'b0, endPtr, 22'b0, startPtr};
	endfunction

	function automatic logic [31:0] ctlAddr(input logic [7:0] offset);
		return 32'(usbBufPkg::CtlWindow) | 32'(offset);
	endfunction

	function automatic logic [31:0] bufAddr(input logic txSide, input logic [7:0] word);
		return 32'(usbBufPkg::BufWindow) | (32'(txSide) << 11) | (32'(word) << 3);
	endfunction

	function automatic usbBufPkg::usbLine_s toggle(input usbBufPkg::usbLine_s level);
		return (level == usbBufPkg::LineJ) ? usbBufPkg::LineK : usbBufPkg::LineJ;
	endfunction

	task automatic checkValue(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("FAIL %s %s: expected %h, actual %h", testName, what, expected, actual);
			$display("Done: errors found");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timeoutFail(input string what);
		$display("timeout in %s while waiting for %s", testName, what);
		$display("Done: errors found");
		$fatal(1, "wait timed out");
	endtask

	task automatic randomByte(output logic [7:0] value);
		value = '0;
		for (int b = 0; b < 8; b++)
		begin
			lfsrState = lfsrStep(lfsrState);
			value = {value[6:0], lfsrState[0]};
		end
	endtask

	// holds the request until Ok, then drops it and waits for Ready
	task automatic busAccess(input logic [31:0] reqAddr, input logic [4:0] reqOpm,
		input logic [63:0] reqData, output logic [63:0] rdData);
		int waitCount;
		waitCount = 0;
		@(posedge clock);
		mmioReq <= '{addr: reqAddr, opm: reqOpm, data: reqData};
		@(negedge clock);
		while (mmioResp.ok != usbBufPkg::MmioOk)
		begin
			if (waitCount == BusTimeout)
			begin
				timeoutFail("bus response Ok");
			end
			else
			begin
				waitCount++;
				@(negedge clock);
			end
		end
		rdData = mmioResp.data;
		@(posedge clock);
		mmioReq.opm <= OpIdle;
		waitCount = 0;
		@(negedge clock);
		while (mmioResp.ok != usbBufPkg::MmioReady)
		begin
			if (waitCount == BusTimeout)
			begin
				timeoutFail("bus response Ready");
			end
			else
			begin
				waitCount++;
				@(negedge clock);
			end
		end
	endtask

	task automatic busWrite(input logic [31:0] reqAddr, input logic [63:0] reqData);
		logic [63:0] unused;
		busAccess(reqAddr, OpWrite, reqData, unused);
	endtask

	task automatic busRead(input logic [31:0] reqAddr, output logic [63:0] rdData);
		busAccess(reqAddr, OpRead, 64'd0, rdData);
	endtask

	// polls the status register until both sides are idle
	task automatic waitIdle(input string what);
		logic [63:0] status;
		int polls;
		polls = 0;
		busRead(ctlAddr(usbBufPkg::RegStatus), status);
		while (status != 64'd0)
		begin
			if (polls == StatusTimeout)
			begin
				timeoutFail(what);
			end
			else
			begin
				polls++;
				busRead(ctlAddr(usbBufPkg::RegStatus), status);
			end
		end
	endtask

	// LFSR bytes plus two 8'hFF, then the expected buffer symbols
	task automatic makePacket(input testRow_s row);
		logic [7:0] value;
		packet.delete();
		symbols.delete();
		for (int i = 0; i < int'(row.count); i++)
		begin
			randomByte(value);
			packet.push_back(value);
		end
		packet[row.ffAt] = 8'hFF;
		packet[row.ffAt + 1] = 8'hFF;
		foreach (packet[i])
		begin
			symbols.push_back({1'b0, packet[i]});
		end
		symbols.push_back(usbBufPkg::EopSymbol);
	endtask

	task automatic sendState(input usbBufPkg::usbLine_s level);
		@(posedge clock);
		lineIn <= level;
		repeat (BitDivide - 1) @(posedge clock);
	endtask

	// sync, packet bytes LSB first with NRZI and stuffing, then SE0 SE0 J
	task automatic encodeLine();
		usbBufPkg::usbLine_s level;
		logic [7:0] value;
		int ones;
		level = usbBufPkg::LineJ;
		ones = 0;
		for (int i = 0; i <= packet.size(); i++)
		begin
			value = (i == 0) ? 8'h80 : packet[i - 1];
			for (int b = 0; b < 8; b++)
			begin
				if (!value[b])
				begin
					level = toggle(level);
				end
				sendState(level);
				ones = value[b] ? ones + 1 : 0;
				if (ones == 6)
				begin
					level = toggle(level);
					sendState(level);
					ones = 0;
				end
			end
		end
		sendState(usbBufPkg::LineSe0);
		sendState(usbBufPkg::LineSe0);
		sendState(usbBufPkg::LineJ);
	endtask

	// samples one state per bit period while lineOe is high, then decodes
	task automatic decodeLine();
		usbBufPkg::usbLine_s prev;
		usbBufPkg::usbLine_s level;
		logic [7:0] shift;
		logic bitVal;
		int waitCount;
		int ones;
		int bitCount;
		int se0Count;
		samples.delete();
		lineBytes.delete();
		waitCount = 0;
		@(negedge clock);
		while (!lineOe)
		begin
			if (waitCount == StartTimeout)
			begin
				timeoutFail("lineOe to rise");
			end
			else
			begin
				waitCount++;
				@(negedge clock);
			end
		end
		while (lineOe)
		begin
			if (samples.size() == MaxSamples)
			begin
				timeoutFail("lineOe to fall");
			end
			else
			begin
				samples.push_back(lineOut);
				repeat (BitDivide) @(negedge clock);
			end
		end
		prev = usbBufPkg::LineJ;
		shift = '0;
		ones = 0;
		bitCount = 0;
		se0Count = 0;
		foreach (samples[i])
		begin
			level = samples[i];
			if (level == usbBufPkg::LineSe0)
			begin
				se0Count++;
			end
			else if (se0Count != 0)
			begin
				// only a single J may follow the end of packet
				checkValue("EOP SE0 length", 64'd2, 64'(se0Count));
				checkValue("idle after EOP", 64'(usbBufPkg::LineJ), 64'(level));
				checkValue("J is last state", 64'(samples.size() - 1), 64'(i));
			end
			else
			begin
				bitVal = level == prev;
				prev = level;
				if (ones == 6)
				begin
					checkValue("stuffed bit", 64'd0, 64'(bitVal));
					ones = 0;
				end
				else
				begin
					ones = bitVal ? ones + 1 : 0;
					shift = {bitVal, shift[7:1]};
					bitCount++;
					if (bitCount == 8)
					begin
						checkValue("sync byte", 64'h80, 64'(shift));
					end
					else if (bitCount % 8 == 0)
					begin
						lineBytes.push_back(shift);
					end
				end
			end
		end
		checkValue("whole bytes on line", 64'd0, 64'(bitCount % 8));
		checkValue("EOP seen", 64'd2, 64'(se0Count));
		checkValue("J ends packet", 64'(usbBufPkg::LineJ), 64'(samples[samples.size() - 1]));
	endtask

	task automatic checkBuffer(input logic txSide, input int first, input string what);
		logic [63:0] rdData;
		int lastPos;
		int pos;
		lastPos = first + symbols.size() - 1;
		for (int w = first / 4; w <= lastPos / 4; w++)
		begin
			busRead(bufAddr(txSide, 8'(w)), rdData);
			for (int k = 0; k < 4; k++)
			begin
				pos = w * 4 + k;
				if (pos >= first && pos <= lastPos)
				begin
					checkValue(what, 64'({7'b0, symbols[pos - first]}), 64'(rdData[16*k +: 16]));
				end
			end
		end
	endtask

	task automatic writeTxWords(input int first);
		logic [63:0] wrData;
		int lastPos;
		int pos;
		lastPos = first + symbols.size() - 1;
		for (int w = first / 4; w <= lastPos / 4; w++)
		begin
			wrData = '0;
			for (int k = 0; k < 4; k++)
			begin
				pos = w * 4 + k;
				if (pos >= first && pos <= lastPos)
				begin
					wrData[16*k +: 9] = symbols[pos - first];
				end
			end
			busWrite(bufAddr(1'b1, 8'(w)), wrData);
		end
	endtask

	task automatic checkPointers(input testRow_s row);
		logic [63:0] rdData;
		busWrite(ctlAddr(usbBufPkg::RegRxPtr), ptrWord(row.rxStart, row.rxEnd));
		busWrite(ctlAddr(usbBufPkg::RegTxPtr), ptrWord(row.txPtr, row.txPtr));
		busRead(ctlAddr(usbBufPkg::RegRxPtr), rdData);
		checkValue("rx pointer readback", ptrWord(row.rxStart, row.rxEnd), rdData);
		busRead(ctlAddr(usbBufPkg::RegTxPtr), rdData);
		checkValue("tx pointer readback", ptrWord(row.txPtr, row.txPtr), rdData);
	endtask

	task automatic checkReceive(input testRow_s row);
		logic [63:0] rdData;
		logic [9:0] endPtr;
		makePacket(row);
		busWrite(ctlAddr(usbBufPkg::RegRxPtr), ptrWord(row.rxEnd, row.rxEnd));
		encodeLine();
		waitIdle("receiver idle");
		endPtr = row.rxEnd + 10'(row.count) + 10'd1;
		busRead(ctlAddr(usbBufPkg::RegRxPtr), rdData);
		checkValue("rx end pointer", ptrWord(row.rxEnd, endPtr), rdData);
		checkBuffer(1'b0, int'(row.rxEnd), "rx buffer symbol");
	endtask

	task automatic checkTransmit(input testRow_s row);
		logic [63:0] rdData;
		logic [9:0] endPtr;
		makePacket(row);
		writeTxWords(int'(row.txPtr));
		checkBuffer(1'b1, int'(row.txPtr), "tx window readback");
		// pointers still equal, so the line stays released
		busRead(ctlAddr(usbBufPkg::RegStatus), rdData);
		checkValue("status before transmit", 64'd0, rdData);
		checkValue("lineOe before transmit", 64'd0, 64'(lineOe));
		endPtr = row.txPtr + 10'(row.count) + 10'd1;
		busWrite(ctlAddr(usbBufPkg::RegTxPtr), ptrWord(row.txPtr, endPtr));
		decodeLine();
		checkValue("decoded byte count", 64'(packet.size()), 64'(lineBytes.size()));
		foreach (packet[i])
		begin
			checkValue("decoded byte", 64'(packet[i]), 64'(lineBytes[i]));
		end
		waitIdle("transmitter idle");
		busRead(ctlAddr(usbBufPkg::RegTxPtr), rdData);
		checkValue("tx pointers after packet", ptrWord(endPtr, endPtr), rdData);
	endtask

	initial
	begin
		logic [63:0] rdData;
		clock = 1'b0;
		reset = 1'b1;
		mmioReq = '0;
		lineIn = usbBufPkg::LineJ;
		lfsrState = 32'h0844_3623;
		testName = "reset";
		rows[0] = '{name: "rowShort", rxStart: 10'd0, rxEnd: 10'd0, txPtr: 10'd0,
			count: 8'd3, ffAt: 8'd0};
		rows[1] = '{name: "rowMixed", rxStart: 10'd5, rxEnd: 10'd9, txPtr: 10'd18,
			count: 8'd6, ffAt: 8'd2};
		rows[2] = '{name: "rowLongs", rxStart: 10'd40, rxEnd: 10'd43, txPtr: 10'd61,
			count: 8'd13, ffAt: 8'd7};
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		checkValue("lineOe", 64'd0, 64'(lineOe));
		checkValue("lineOut", 64'(usbBufPkg::LineJ), 64'(lineOut));
		checkValue("bus ok", 64'(usbBufPkg::MmioReady), 64'(mmioResp.ok));
		busRead(ctlAddr(usbBufPkg::RegRxPtr), rdData);
		checkValue("rx pointers", 64'd0, rdData);
		busRead(ctlAddr(usbBufPkg::RegTxPtr), rdData);
		checkValue("tx pointers", 64'd0, rdData);
		busRead(ctlAddr(usbBufPkg::RegStatus), rdData);
		checkValue("status", 64'd0, rdData);
		for (int r = 0; r < NumRows; r++)
		begin
			$sformat(testName, "%s", rows[r].name);
			checkPointers(rows[r]);
			checkReceive(rows[r]);
			checkTransmit(rows[r]);
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
source/usbBufPkg.sv
source/usbBitTimer.sv
source/usbPacketBuffer.sv
source/usbRxDecoder.sv
source/usbTxEncoder.sv
source/usbBufMmioCtrl.sv
source/usbBufTop.sv
verification/usbBufTb.sv
